// File: all.f
+incdir+include
src/fdec_pkg.sv
src/fdec_classify.sv
src/fdec_operands.sv
src/fdec_top.sv
tb/fdec_chk.sv
tb/fdec_tb.sv

// File: Makefile
TOP := fdec_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tb/fdec_tb.sv
`timescale 1ns/10ps
`include "fdec_defines.svh"

module fdec_tb import fdec_pkg::*;;

localparam int WAIT_LIMIT = 16; // cycles to wait for a result
// fmadd with every register field at 31, driven while the strobe is low
localparam instr_t HOLD_INSTR = {5'd31, `FMT_S, 5'd31, 5'd31, 3'b111, 5'd31, `OPC_MADD};

logic clk_i;
logic rst_n_i;
logic instr_valid_i;
instr_t instr_i;
logic dec_valid_o;
logic is_float_o;
fdec_out_t dec_o;

logic [31:0] rng_state = 32'd67019;
int n_checks = 0;
int n_errors = 0;
int n_timeouts = 0;
string cur_name = "reset";

fdec_top i_fdec_top (.*);

initial begin
	clk_i = 1'b0;
	forever #4 clk_i = ~clk_i;
end

// ==============================
// random fields and encodings
// ==============================

// xorshift32
function automatic logic [31:0] rand32();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function automatic logic [4:0] rand5();
	logic [31:0] r;
	r = rand32();
	return r[4:0];
endfunction

// rs1 and rd are drawn at random
function automatic instr_t encode(input logic [4:0] f5, input logic [1:0] fmt,
		input logic [4:0] rs2, input logic [2:0] rm, input logic [6:0] opc);
	logic [31:0] r;
	r = rand32();
	return {f5, fmt, rs2, r[4:0], rm, r[9:5], opc};
endfunction

function automatic instr_t op_fp(input logic [4:0] f5, input logic [4:0] rs2,
		input logic [2:0] rm);
	return encode(f5, `FMT_S, rs2, rm, `OPC_OP_FP);
endfunction

// ==============================
// expected result
// ==============================

function automatic fdec_out_t expect_dec(input instr_t ins, input fshape_t shape,
		input fu_func_t code);
	fdec_out_t e;
	logic [9:0] cfg; // use bits rs1 rs2 rs3 rd, float bank of each, sel_b and sel_c on reg
	case (shape)
		SHAPE_FF_F:  cfg = 10'b1101_1101_10;
		SHAPE_FF_X:  cfg = 10'b1101_1100_10;
		SHAPE_FFF_F: cfg = 10'b1111_1111_11;
		SHAPE_F_F:   cfg = 10'b1001_1001_00;
		SHAPE_F_X:   cfg = 10'b1001_1000_00;
		SHAPE_X_F:   cfg = 10'b1001_0001_00;
		SHAPE_LOAD:  cfg = 10'b1001_0001_00;
		SHAPE_STORE: cfg = 10'b1100_0100_00;
		default:     cfg = '0;
	endcase
	e = '0;
	{e.uses_rs1, e.uses_rs2, e.uses_rs3, e.uses_rd} = cfg[9:6];
	// the float bank sets bit 5 (offset 32)
	e.rs1_addr = cfg[9] ? {cfg[5], ins[19:15]} : '0;
	e.rs2_addr = cfg[8] ? {cfg[4], ins[24:20]} : '0;
	e.rs3_addr = cfg[7] ? {cfg[3], ins[31:27]} : '0;
	e.rd_addr = cfg[6] ? {cfg[2], ins[11:7]} : '0;
	e.sel_a = (shape == SHAPE_NONE) ? `ALU_SEL_IMM : `ALU_SEL_REG;
	e.sel_b = cfg[1] ? `ALU_SEL_REG : `ALU_SEL_IMM;
	e.sel_c = cfg[0] ? `ALU_SEL_REG : `ALU_SEL_IMM;
	if (shape == SHAPE_LOAD)
		e.imm = ins[31:20];
	if (shape == SHAPE_STORE)
		e.imm = {ins[31:25], ins[11:7]};
	if (shape != SHAPE_NONE)
		e.fu_function = code;
	return e;
endfunction

// ==============================
// compare tasks
// ==============================

task automatic report_diff(input string name, input logic [31:0] exp, input logic [31:0] act);
	n_checks++;
	if (exp !== act) begin
		n_errors++;
		$display("ERR t=%0t %s exp=%0h act=%0h (%s)", $time, name, exp, act, cur_name);
	end
endtask

task automatic check_dec(input fdec_out_t exp, input fdec_out_t act);
	report_diff("dec_o.uses_rs1", 32'(exp.uses_rs1), 32'(act.uses_rs1));
	report_diff("dec_o.uses_rs2", 32'(exp.uses_rs2), 32'(act.uses_rs2));
	report_diff("dec_o.uses_rs3", 32'(exp.uses_rs3), 32'(act.uses_rs3));
	report_diff("dec_o.uses_rd", 32'(exp.uses_rd), 32'(act.uses_rd));
	report_diff("dec_o.rs1_addr", 32'(exp.rs1_addr), 32'(act.rs1_addr));
	report_diff("dec_o.rs2_addr", 32'(exp.rs2_addr), 32'(act.rs2_addr));
	report_diff("dec_o.rs3_addr", 32'(exp.rs3_addr), 32'(act.rs3_addr));
	report_diff("dec_o.rd_addr", 32'(exp.rd_addr), 32'(act.rd_addr));
	report_diff("dec_o.imm", 32'(exp.imm), 32'(act.imm));
	report_diff("dec_o.sel_a", 32'(exp.sel_a), 32'(act.sel_a));
	report_diff("dec_o.sel_b", 32'(exp.sel_b), 32'(act.sel_b));
	report_diff("dec_o.sel_c", 32'(exp.sel_c), 32'(act.sel_c));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	report_diff(name, 32'(exp), 32'(act));
endtask

task automatic check_func(input fu_func_t exp, input fu_func_t act);
	report_diff("dec_o.fu_function", 32'(exp), 32'(act));
endtask

task automatic check_result(input instr_t ins, input fshape_t shape, input fu_func_t code);
	fdec_out_t exp;
	exp = expect_dec(ins, shape, code);
	check_flag("is_float_o", shape != SHAPE_NONE, is_float_o);
	check_dec(exp, dec_o);
	check_func(exp.fu_function, dec_o.fu_function);
endtask

// one strobe, then wait for the registered result
task automatic run_one(input string name, input instr_t ins, input fshape_t shape,
		input fu_func_t code);
	int waited;
	cur_name = name;
	waited = 0;
	@(posedge clk_i);
	instr_valid_i <= 1'b1;
	instr_i <= ins;
	@(posedge clk_i);
	instr_valid_i <= 1'b0;
	instr_i <= HOLD_INSTR;
	@(negedge clk_i);
	while (!dec_valid_o && waited < WAIT_LIMIT) begin
		@(negedge clk_i);
		waited++;
	end
	if (dec_valid_o) begin
		check_result(ins, shape, code);
		// the outputs keep the result while the strobe is low
		@(negedge clk_i);
		cur_name = {name, " hold"};
		check_result(ins, shape, code);
	end else begin
		n_timeouts++;
		$display("%s: dec_valid_o did not rise within %0d cycles", name, WAIT_LIMIT);
	end
endtask

// ==============================
// directed tests
// ==============================

task automatic test_reset();
	fdec_out_t zero;
	zero = '0;
	for (int i = 0; i < 11; i++) begin
		@(posedge clk_i);
		instr_valid_i <= (i < 9); // strobes during reset are dropped
		instr_i <= op_fp(5'b00000, rand5(), 3'b000);
		if (i == 9)
			rst_n_i <= 1'b1;
		@(negedge clk_i);
		check_flag("dec_valid_o", 1'b0, dec_valid_o);
		check_flag("is_float_o", 1'b0, is_float_o);
		check_dec(zero, dec_o);
		check_func('0, dec_o.fu_function);
	end
endtask

task automatic test_arith();
	run_one("fadd", op_fp(5'b00000, rand5(), 3'(rand5())), SHAPE_FF_F, 5'd0);
	run_one("fsub", op_fp(5'b00001, rand5(), 3'(rand5())), SHAPE_FF_F, 5'd1);
	run_one("fmul", op_fp(5'b00010, rand5(), 3'(rand5())), SHAPE_FF_F, 5'd2);
	run_one("fdiv", op_fp(5'b00011, rand5(), 3'(rand5())), SHAPE_FF_F, 5'd26);
	run_one("fmin", op_fp(5'b00101, rand5(), 3'b000), SHAPE_FF_F, 5'd3);
	run_one("fmax", op_fp(5'b00101, rand5(), 3'b001), SHAPE_FF_F, 5'd4);
	run_one("fsgnj", op_fp(5'b00100, rand5(), 3'b000), SHAPE_FF_F, 5'd17);
	run_one("fsgnjn", op_fp(5'b00100, rand5(), 3'b001), SHAPE_FF_F, 5'd18);
	run_one("fsgnjx", op_fp(5'b00100, rand5(), 3'b010), SHAPE_FF_F, 5'd19);
	run_one("fsqrt", op_fp(5'b01011, 5'd0, 3'(rand5())), SHAPE_F_F, 5'd27);
endtask

task automatic test_fused();
	run_one("fmadd", encode(rand5(), `FMT_S, rand5(), 3'(rand5()), `OPC_MADD), SHAPE_FFF_F, 5'd5);
	run_one("fmsub", encode(rand5(), `FMT_S, rand5(), 3'(rand5()), `OPC_MSUB), SHAPE_FFF_F, 5'd7);
	run_one("fnmsub", encode(rand5(), `FMT_S, rand5(), 3'b000, `OPC_NMSUB), SHAPE_FFF_F, 5'd8);
	run_one("fnmadd", encode(rand5(), `FMT_S, rand5(), 3'b111, `OPC_NMADD), SHAPE_FFF_F, 5'd6);
endtask

task automatic test_convert();
	run_one("fcvt.w.s", op_fp(5'b11000, 5'd0, 3'(rand5())), SHAPE_F_X, 5'd9);
	run_one("fcvt.wu.s", op_fp(5'b11000, 5'd1, 3'(rand5())), SHAPE_F_X, 5'd10);
	run_one("fcvt.s.w", op_fp(5'b11010, 5'd0, 3'(rand5())), SHAPE_X_F, 5'd13);
	run_one("fcvt.s.wu", op_fp(5'b11010, 5'd1, 3'(rand5())), SHAPE_X_F, 5'd14);
	run_one("feq", op_fp(5'b10100, rand5(), 3'b010), SHAPE_FF_X, 5'd20);
	run_one("flt", op_fp(5'b10100, rand5(), 3'b001), SHAPE_FF_X, 5'd21);
	run_one("fle", op_fp(5'b10100, rand5(), 3'b000), SHAPE_FF_X, 5'd22);
	run_one("fclass", op_fp(5'b11100, 5'd0, 3'b001), SHAPE_F_X, 5'd23);
	run_one("fmv.x.w", op_fp(5'b11100, 5'd0, 3'b000), SHAPE_F_X, 5'd25);
	run_one("fmv.w.x", op_fp(5'b11110, 5'd0, 3'b000), SHAPE_X_F, 5'd24);
endtask

task automatic test_mem();
	logic [31:0] r;
	for (int i = 0; i < 3; i++) begin
		r = rand32();
		run_one("flw", {r[31:20], r[4:0], `WIDTH_W, r[9:5], `OPC_LOAD_FP}, SHAPE_LOAD, 5'd28);
		run_one("fsw", {r[31:25], r[14:10], r[4:0], `WIDTH_W, r[24:20], `OPC_STORE_FP},
			SHAPE_STORE, 5'd29);
	end
endtask

task automatic test_not_float();
	run_one("fadd fmt d", encode(5'b00000, 2'b01, rand5(), 3'b000, `OPC_OP_FP), SHAPE_NONE, 5'd0);
	run_one("fcvt.l.s", op_fp(5'b11000, 5'd2, 3'b000), SHAPE_NONE, 5'd0);
	run_one("fcvt.lu.s", op_fp(5'b11000, 5'd3, 3'b000), SHAPE_NONE, 5'd0);
	run_one("fcvt.s.l", op_fp(5'b11010, 5'd2, 3'b000), SHAPE_NONE, 5'd0);
	run_one("fcvt.s.lu", op_fp(5'b11010, 5'd3, 3'b000), SHAPE_NONE, 5'd0);
	run_one("fld", encode(rand5(), 2'b00, rand5(), 3'b011, `OPC_LOAD_FP), SHAPE_NONE, 5'd0);
	run_one("add", encode(5'b00000, 2'b00, rand5(), 3'b000, 7'b0110011), SHAPE_NONE, 5'd0);
endtask

// strobes on consecutive cycles give one result per cycle
task automatic test_stream();
	instr_t ins[5];
	fshape_t shp[5] = '{SHAPE_FF_F, SHAPE_FFF_F, SHAPE_NONE, SHAPE_FF_X, SHAPE_STORE};
	fu_func_t code[5] = '{5'd2, 5'd7, 5'd0, 5'd21, 5'd29};
	ins[0] = op_fp(5'b00010, rand5(), 3'b000);
	ins[1] = encode(rand5(), `FMT_S, rand5(), 3'b000, `OPC_MSUB);
	ins[2] = encode(5'b00000, 2'b00, rand5(), 3'b000, 7'b0110011);
	ins[3] = op_fp(5'b10100, rand5(), 3'b001);
	ins[4] = encode(rand5(), 2'(rand5()), rand5(), `WIDTH_W, `OPC_STORE_FP);
	for (int i = 0; i <= 5; i++) begin
		@(posedge clk_i);
		instr_valid_i <= (i < 5);
		if (i < 5)
			instr_i <= ins[i];
		@(negedge clk_i);
		if (i > 0) begin
			cur_name = $sformatf("stream item %0d", i - 1);
			check_flag("dec_valid_o", 1'b1, dec_valid_o);
			check_result(ins[i-1], shp[i-1], code[i-1]);
		end
	end
	@(posedge clk_i);
	@(negedge clk_i);
	check_flag("dec_valid_o", 1'b0, dec_valid_o); // no extra result
endtask

initial begin
	rst_n_i = 1'b0;
	instr_valid_i = 1'b0;
	instr_i = '0;
	test_reset();
	test_arith();
	test_fused();
	test_convert();
	test_mem();
	test_not_float();
	test_stream();
	$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
	if (n_errors == 0 && n_timeouts == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

// File: tb/fdec_chk.sv
`timescale 1ns/10ps

module fdec_chk import fdec_pkg::*; (
	input logic      clk_i,
	input logic      rst_n_i,
	input logic      instr_valid_i,
	input logic      dec_valid_i,
	input logic      is_float_i,
	input fdec_out_t dec_i
);

// ==============================
// handshake
// ==============================

a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	dec_valid_i == $past(instr_valid_i && rst_n_i))
	else $error("result strobe not one cycle after instr_valid_i");

a_new_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	($rose(is_float_i) || (is_float_i && dec_i != $past(dec_i))) |-> dec_valid_i)
	else $error("float result changed without a result strobe");

// ==============================
// operand fields
// ==============================

a_unused_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	(dec_i.uses_rs1 || dec_i.rs1_addr == '0) && (dec_i.uses_rs2 || dec_i.rs2_addr == '0) &&
	(dec_i.uses_rs3 || dec_i.rs3_addr == '0) && (dec_i.uses_rd || dec_i.rd_addr == '0))
	else $error("unused register address is not zero");

a_no_float_no_use: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	!is_float_i |-> {dec_i.uses_rs1, dec_i.uses_rs2, dec_i.uses_rs3, dec_i.uses_rd} == 4'b0)
	else $error("use bits set on a non-float result");

endmodule

bind fdec_top fdec_chk i_fdec_chk (
	.clk_i         (clk_i),
	.rst_n_i       (rst_n_i),
	.instr_valid_i (instr_valid_i),
	.dec_valid_i   (dec_valid_o),
	.is_float_i    (is_float_o),
	.dec_i         (dec_o)
);

// File: src/fdec_top.sv
`timescale 1ns/10ps

module fdec_top import fdec_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      instr_valid_i,
	input  instr_t    instr_i,
	output logic      dec_valid_o,
	output logic      is_float_o,
	output fdec_out_t dec_o
);

fdec_fields_t fields;
fdec_ctrl_t ctrl;
fdec_out_t dec;
logic is_float;

// ==============================
// decode
// ==============================

assign fields = fdec_fields_t'(instr_i);

fdec_classify i_fdec_classify (
	.fields_i (fields),
	.ctrl_o   (ctrl)
);

fdec_operands i_fdec_operands (
	.fields_i (fields),
	.ctrl_i   (ctrl),
	.dec_o    (dec)
);

assign is_float = (ctrl.shape != SHAPE_NONE);

// ==============================
// output register
// ==============================

always_ff @(posedge clk_i) begin
	if (!rst_n_i) begin
		dec_valid_o <= 1'b0;
		is_float_o <= 1'b0;
		dec_o <= '0;
	end else begin
		dec_valid_o <= instr_valid_i;
		// result holds between strobes
		if (instr_valid_i) begin
			is_float_o <= is_float;
			dec_o <= dec;
		end
	end
end

endmodule

// File: src/fdec_operands.sv
`timescale 1ns/10ps
`include "fdec_defines.svh"

module fdec_operands import fdec_pkg::*; (
	input  fdec_fields_t fields_i,
	input  fdec_ctrl_t   ctrl_i,
	output fdec_out_t    dec_o
);

// unused operands read as address 0
function automatic vreg_addr_t vaddr(input reg_num_t num, input logic used, input logic is_fp);
	vreg_addr_t base;
	base = vreg_addr_t'(num);
	if (!used)
		return '0;
	if (is_fp)
		return base + vreg_addr_t'(`FP_BANK_OFFSET);
	return base;
endfunction

logic rs1_fp;
logic rs2_fp;
logic rd_fp; // rs3 is always a float reg

// ==============================
// shape table
// ==============================

always_comb begin
	dec_o = '0;
	dec_o.sel_a = `ALU_SEL_IMM;
	dec_o.sel_b = `ALU_SEL_IMM;
	dec_o.sel_c = `ALU_SEL_IMM;
	rs1_fp = 1'b0;
	rs2_fp = 1'b0;
	rd_fp = 1'b0;

	case (ctrl_i.shape)
		SHAPE_FF_F, SHAPE_FF_X: begin
			dec_o.uses_rs1 = 1'b1;
			dec_o.uses_rs2 = 1'b1;
			dec_o.uses_rd = 1'b1;
			rs1_fp = 1'b1;
			rs2_fp = 1'b1;
			rd_fp = (ctrl_i.shape == SHAPE_FF_F); // compares write x regs
			dec_o.sel_a = `ALU_SEL_REG;
			dec_o.sel_b = `ALU_SEL_REG;
		end
		SHAPE_FFF_F: begin
			dec_o.uses_rs1 = 1'b1;
			dec_o.uses_rs2 = 1'b1;
			dec_o.uses_rs3 = 1'b1;
			dec_o.uses_rd = 1'b1;
			rs1_fp = 1'b1;
			rs2_fp = 1'b1;
			rd_fp = 1'b1;
			dec_o.sel_a = `ALU_SEL_REG;
			dec_o.sel_b = `ALU_SEL_REG;
			dec_o.sel_c = `ALU_SEL_REG;
		end
		SHAPE_F_F, SHAPE_F_X: begin
			dec_o.uses_rs1 = 1'b1;
			dec_o.uses_rd = 1'b1;
			rs1_fp = 1'b1;
			rd_fp = (ctrl_i.shape == SHAPE_F_F);
			dec_o.sel_a = `ALU_SEL_REG;
		end
		SHAPE_X_F: begin
			dec_o.uses_rs1 = 1'b1;
			dec_o.uses_rd = 1'b1;
			rd_fp = 1'b1;
			dec_o.sel_a = `ALU_SEL_REG;
		end
		SHAPE_LOAD: begin
			dec_o.uses_rs1 = 1'b1; // base address
			dec_o.uses_rd = 1'b1;
			rd_fp = 1'b1;
			dec_o.sel_a = `ALU_SEL_REG;
			dec_o.imm = {fields_i.funct5, fields_i.fmt, fields_i.rs2}; // i-form
		end
		SHAPE_STORE: begin
			dec_o.uses_rs1 = 1'b1;
			dec_o.uses_rs2 = 1'b1; // store data
			rs2_fp = 1'b1;
			dec_o.sel_a = `ALU_SEL_REG;
			dec_o.imm = {fields_i.funct5, fields_i.fmt, fields_i.rd}; // s-form
		end
		default: ;
	endcase

	dec_o.rs1_addr = vaddr(fields_i.rs1, dec_o.uses_rs1, rs1_fp);
	dec_o.rs2_addr = vaddr(fields_i.rs2, dec_o.uses_rs2, rs2_fp);
	dec_o.rs3_addr = vaddr(fields_i.funct5, dec_o.uses_rs3, 1'b1);
	dec_o.rd_addr = vaddr(fields_i.rd, dec_o.uses_rd, rd_fp);
	dec_o.fu_function = fu_func_t'(ctrl_i.op);
end

endmodule

// File: src/fdec_classify.sv
`timescale 1ns/10ps
`include "fdec_defines.svh"

module fdec_classify import fdec_pkg::*; (
	input  fdec_fields_t fields_i,
	output fdec_ctrl_t   ctrl_o
);

fdec_ctrl_t cand; // match on opcode/funct5 before the fmt and width checks
logic fmt_s;
logic width_w;
logic rs2_zero;
logic is_mem;

assign fmt_s = (fields_i.fmt == `FMT_S);
assign width_w = (fields_i.rm == `WIDTH_W);
assign rs2_zero = (fields_i.rs2 == 5'd0);

// ==============================
// instruction match
// ==============================

always_comb begin
	cand = '{FOP_NONE, SHAPE_NONE};
	case (fields_i.opcode)
		`OPC_MADD:     cand = '{FOP_FMADD, SHAPE_FFF_F};
		`OPC_MSUB:     cand = '{FOP_FMSUB, SHAPE_FFF_F};
		`OPC_NMSUB:    cand = '{FOP_FNMSUB, SHAPE_FFF_F};
		`OPC_NMADD:    cand = '{FOP_FNMADD, SHAPE_FFF_F};
		`OPC_LOAD_FP:  cand = '{FOP_FLW, SHAPE_LOAD};
		`OPC_STORE_FP: cand = '{FOP_FSW, SHAPE_STORE};
		`OPC_OP_FP: begin
			case (fields_i.funct5)
				5'b00000: cand = '{FOP_FADD, SHAPE_FF_F};
				5'b00001: cand = '{FOP_FSUB, SHAPE_FF_F};
				5'b00010: cand = '{FOP_FMUL, SHAPE_FF_F};
				5'b00011: cand = '{FOP_FDIV, SHAPE_FF_F};
				5'b01011: if (rs2_zero) cand = '{FOP_FSQRT, SHAPE_F_F};
				5'b00100: begin // sign injection
					case (fields_i.rm)
						3'b000: cand = '{FOP_FSGNJ, SHAPE_FF_F};
						3'b001: cand = '{FOP_FSGNJN, SHAPE_FF_F};
						3'b010: cand = '{FOP_FSGNJX, SHAPE_FF_F};
						default: ;
					endcase
				end
				5'b00101: begin
					case (fields_i.rm)
						3'b000: cand = '{FOP_FMIN, SHAPE_FF_F};
						3'b001: cand = '{FOP_FMAX, SHAPE_FF_F};
						default: ;
					endcase
				end
				5'b10100: begin // compares write an integer reg
					case (fields_i.rm)
						3'b010: cand = '{FOP_FEQ, SHAPE_FF_X};
						3'b001: cand = '{FOP_FLT, SHAPE_FF_X};
						3'b000: cand = '{FOP_FLE, SHAPE_FF_X};
						default: ;
					endcase
				end
				5'b11000: begin
					case (fields_i.rs2)
						5'd0: cand = '{FOP_FCVT_W_S, SHAPE_F_X};
						5'd1: cand = '{FOP_FCVT_WU_S, SHAPE_F_X};
						default: ; // l/lu forms are rv64 only
					endcase
				end
				5'b11010: begin
					case (fields_i.rs2)
						5'd0: cand = '{FOP_FCVT_S_W, SHAPE_X_F};
						5'd1: cand = '{FOP_FCVT_S_WU, SHAPE_X_F};
						default: ;
					endcase
				end
				5'b11100: begin
					if (rs2_zero && fields_i.rm == 3'b000)
						cand = '{FOP_FMV_X_W, SHAPE_F_X};
					else if (rs2_zero && fields_i.rm == 3'b001)
						cand = '{FOP_FCLASS, SHAPE_F_X};
				end
				5'b11110: begin
					if (rs2_zero && fields_i.rm == 3'b000)
						cand = '{FOP_FMV_W_X, SHAPE_X_F};
				end
				default: ;
			endcase
		end
		default: ;
	endcase
end

// loads and stores check the width field, everything else the format
assign is_mem = (cand.shape == SHAPE_LOAD) || (cand.shape == SHAPE_STORE);

always_comb begin
	ctrl_o = cand;
	if (is_mem ? !width_w : !fmt_s)
		ctrl_o = '{FOP_NONE, SHAPE_NONE};
end

endmodule

// File: src/fdec_pkg.sv
`include "fdec_defines.svh"

package fdec_pkg;

typedef logic [31:0] instr_t;
typedef logic [4:0] reg_num_t; // architectural register number
typedef logic [`VIR_REG_ADDR_WIDTH-1:0] vreg_addr_t;
typedef logic [`IMM_WIDTH-1:0] imm_t;
typedef logic [`FU_FUNC_WIDTH-1:0] fu_func_t;
typedef logic [1:0] alu_sel_t;

// function codes of the functional unit
// 11, 12, 15 and 16 were the rv64 conversions and stay free
typedef enum logic [`FU_FUNC_WIDTH-1:0] {
	FOP_FADD      = 5'd0,
	FOP_FSUB      = 5'd1,
	FOP_FMUL      = 5'd2,
	FOP_FMIN      = 5'd3,
	FOP_FMAX      = 5'd4,
	FOP_FMADD     = 5'd5,
	FOP_FNMADD    = 5'd6,
	FOP_FMSUB     = 5'd7,
	FOP_FNMSUB    = 5'd8,
	FOP_FCVT_W_S  = 5'd9,
	FOP_FCVT_WU_S = 5'd10,
	FOP_FCVT_S_W  = 5'd13,
	FOP_FCVT_S_WU = 5'd14,
	FOP_FSGNJ     = 5'd17,
	FOP_FSGNJN    = 5'd18,
	FOP_FSGNJX    = 5'd19,
	FOP_FEQ       = 5'd20,
	FOP_FLT       = 5'd21,
	FOP_FLE       = 5'd22,
	FOP_FCLASS    = 5'd23,
	FOP_FMV_W_X   = 5'd24,
	FOP_FMV_X_W   = 5'd25,
	FOP_FDIV      = 5'd26,
	FOP_FSQRT     = 5'd27,
	FOP_FLW       = 5'd28,
	FOP_FSW       = 5'd29
} fop_t;

// shares code 0 with fadd, SHAPE_NONE tells them apart
localparam fop_t FOP_NONE = FOP_FADD;

typedef enum logic [3:0] {
	SHAPE_NONE  = 4'd0,
	SHAPE_FF_F  = 4'd1, // two float sources, float dest
	SHAPE_FFF_F = 4'd2, // fused multiply-add family
	SHAPE_F_F   = 4'd3, // fsqrt
	SHAPE_F_X   = 4'd4,
	SHAPE_X_F   = 4'd5,
	SHAPE_FF_X  = 4'd6, // compares
	SHAPE_LOAD  = 4'd7,
	SHAPE_STORE = 4'd8
} fshape_t;

// overlay of the instruction word
typedef struct packed {
	logic [4:0] funct5; // rs3 for the fused ops
	logic [1:0] fmt;
	reg_num_t rs2;
	reg_num_t rs1;
	logic [2:0] rm; // width field of flw/fsw
	reg_num_t rd;
	logic [6:0] opcode;
} fdec_fields_t;

typedef struct packed {
	fop_t op;
	fshape_t shape;
} fdec_ctrl_t;

typedef struct packed {
	logic uses_rs1;
	logic uses_rs2;
	logic uses_rs3;
	logic uses_rd;
	vreg_addr_t rs1_addr;
	vreg_addr_t rs2_addr;
	vreg_addr_t rs3_addr;
	vreg_addr_t rd_addr;
	imm_t imm;
	fu_func_t fu_function;
	alu_sel_t sel_a;
	alu_sel_t sel_b;
	alu_sel_t sel_c;
} fdec_out_t;

endpackage

// File: include/fdec_defines.svh
`ifndef FDEC_DEFINES_SVH
`define FDEC_DEFINES_SVH

// ==============================
// widths
// ==============================

`define VIR_REG_ADDR_WIDTH 6
`define FP_BANK_OFFSET     32 // float regs live above the 32 integer regs
`define IMM_WIDTH          12
`define FU_FUNC_WIDTH      5

// ==============================
// major opcodes
// ==============================

`define OPC_OP_FP    7'b1010011
`define OPC_MADD     7'b1000011
`define OPC_MSUB     7'b1000111
`define OPC_NMSUB    7'b1001011
`define OPC_NMADD    7'b1001111
`define OPC_LOAD_FP  7'b0000111
`define OPC_STORE_FP 7'b0100111

// format and memory width fields
`define FMT_S   2'b00
`define WIDTH_W 3'b010

// operand select codes of the functional unit
`define ALU_SEL_REG 2'b00
`define ALU_SEL_IMM 2'b01

`endif
